//--- common/rv_isa_pkg.sv
// rv32i opcode, funct and instruction format definitions shared by decode and the testbench
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op     = 7'b0110011,
        op_op_imm = 7'b0010011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // funct3 for alu ops, shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // funct7 marking sub in r-type
    localparam logic [6:0] f7_sub_alt = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    // branch offset scattered around the register fields
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, read through whichever format applies
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

//--- common/ctrl_pkg.sv
// pipeline control word, alu operation codes and stage register layouts
package ctrl_pkg;

    // next pc source, same codes as the old jump field
    typedef enum logic [1:0] {
        pc_seq  = 2'b01,
        pc_jal  = 2'b10,
        pc_trap = 2'b11
    } pc_sel_e;

    // writeback result source
    typedef enum logic [1:0] {
        res_alu  = 2'b00,
        res_mem  = 2'b01,
        res_link = 2'b10
    } result_sel_e;

    // coarse alu class handed to alu_deco
    typedef enum logic [1:0] {
        sel_add    = 2'b00,
        sel_branch = 2'b01,
        sel_funct  = 2'b10
    } alu_sel_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic        branch;
        pc_sel_e     pc_sel;
        result_sel_e result_sel;
        logic        mem_w;
        logic        alu_src_imm;
        logic        reg_w;
        alu_sel_e    alu_sel;
        logic        illegal;
    } ctrl_t;

    // decode to execute
    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        alu_op_e     alu_op;
        logic [2:0]  funct3;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
    } dec_ex_t;

    // execute to writeback
    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] alu_res;
        logic [31:0] store_data;
        logic [31:0] link;
        logic [4:0]  rd;
    } ex_wb_t;

endpackage

//--- decode/main_deco.sv
// main control decoder, turns an opcode into the pipeline control word
`timescale 1ns/1ns

module main_deco (
    input  rv_isa_pkg::opcode_e op_code,
    output ctrl_pkg::ctrl_t     ctrl
);

    always_comb
    begin
        // safe defaults, every class overrides what it needs
        ctrl             = '0;
        ctrl.pc_sel      = ctrl_pkg::pc_seq;
        ctrl.result_sel  = ctrl_pkg::res_alu;
        ctrl.alu_sel     = ctrl_pkg::sel_add;
        case (op_code)
            rv_isa_pkg::op_load:
            begin
                // address is rs1 + imm, data from memory
                ctrl.result_sel  = ctrl_pkg::res_mem;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_w       = 1'b1;
            end
            rv_isa_pkg::op_store:
            begin
                ctrl.mem_w       = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            rv_isa_pkg::op_op:
            begin
                ctrl.reg_w   = 1'b1;
                ctrl.alu_sel = ctrl_pkg::sel_funct;
            end
            rv_isa_pkg::op_branch:
            begin
                // compare rs1 against rs2, no write
                ctrl.branch  = 1'b1;
                ctrl.alu_sel = ctrl_pkg::sel_branch;
            end
            rv_isa_pkg::op_op_imm:
            begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_w       = 1'b1;
                ctrl.alu_sel     = ctrl_pkg::sel_funct;
            end
            rv_isa_pkg::op_jal:
            begin
                // rd gets pc + 4, alu result unused
                ctrl.pc_sel      = ctrl_pkg::pc_jal;
                ctrl.result_sel  = ctrl_pkg::res_link;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_w       = 1'b1;
            end
            default:
            begin
                // csr and anything unknown end up here
                ctrl.pc_sel  = ctrl_pkg::pc_trap;
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    // no class both stores and writes a register
    always_comb
    begin
        assert (!(ctrl.mem_w && ctrl.reg_w))
            else $error("main_deco: mem_w and reg_w both set");
    end

endmodule

//--- decode/alu_deco.sv
// alu decoder, maps the alu class and funct fields to an alu operation
`timescale 1ns/1ns

module alu_deco (
    input  ctrl_pkg::alu_sel_e alu_sel,
    input  logic [2:0]         funct3,
    input  logic               funct7_b5,
    input  logic               is_op,
    output ctrl_pkg::alu_op_e  alu_op
);

    always_comb
    begin
        case (alu_sel)
            ctrl_pkg::sel_branch:
            begin
                // funct3[2] splits equality tests from signed less-than
                alu_op = funct3[2] ? ctrl_pkg::alu_slt : ctrl_pkg::alu_sub;
            end
            ctrl_pkg::sel_funct:
            begin
                case (funct3)
                    rv_isa_pkg::f3_add_sub:
                    begin
                        // addi has no sub, the funct7 bit is part of its imm
                        alu_op = (is_op && funct7_b5) ? ctrl_pkg::alu_sub : ctrl_pkg::alu_add;
                    end
                    rv_isa_pkg::f3_slt: alu_op = ctrl_pkg::alu_slt;
                    rv_isa_pkg::f3_or:  alu_op = ctrl_pkg::alu_or;
                    rv_isa_pkg::f3_and: alu_op = ctrl_pkg::alu_and;
                    default:            alu_op = ctrl_pkg::alu_add;
                endcase
            end
            // loads, stores, jal
            default: alu_op = ctrl_pkg::alu_add;
        endcase
    end

endmodule

//--- decode/decode_stage.sv
// decode stage, reads operands, builds the immediate and registers the decode bundle
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  rv_isa_pkg::instr_u  instr,
    input  logic [31:0]         pc,
    input  logic [31:0]         rs1_data,
    input  logic [31:0]         rs2_data,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    output ctrl_pkg::dec_ex_t   dec_ex
);

    ctrl_pkg::ctrl_t   deco_ctrl;
    ctrl_pkg::alu_op_e deco_alu_op;
    logic [31:0]       imm;

    // register indices sit at the same place in every format
    assign rs1_addr = instr.r_fmt.rs1;
    assign rs2_addr = instr.r_fmt.rs2;

    main_deco u_main_deco (
        .op_code (instr.r_fmt.opcode),
        .ctrl    (deco_ctrl)
    );

    alu_deco u_alu_deco (
        .alu_sel   (deco_ctrl.alu_sel),
        .funct3    (instr.r_fmt.funct3),
        .funct7_b5 (instr.r_fmt.funct7[5]),
        .is_op     (instr.r_fmt.opcode == rv_isa_pkg::op_op),
        .alu_op    (deco_alu_op)
    );

    // sign extended immediate, view picked by opcode
    always_comb
    begin
        case (instr.r_fmt.opcode)
            rv_isa_pkg::op_load, rv_isa_pkg::op_op_imm:
                imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            rv_isa_pkg::op_store:
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            rv_isa_pkg::op_branch:
                imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            rv_isa_pkg::op_jal:
                imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dec_ex <= '0;
        end
        else
        begin
            dec_ex.valid   <= instr_valid;
            // bubbles carry an all-zero control word
            dec_ex.ctrl    <= instr_valid ? deco_ctrl : '0;
            dec_ex.alu_op  <= deco_alu_op;
            dec_ex.funct3  <= instr.r_fmt.funct3;
            dec_ex.pc      <= pc;
            dec_ex.rs1_val <= rs1_data;
            dec_ex.rs2_val <= rs2_data;
            dec_ex.imm     <= imm;
            dec_ex.rd      <= instr.r_fmt.rd;
        end
    end

    // an idle input slot never turns into a write one cycle later
    a_bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !(dec_ex.ctrl.reg_w || dec_ex.ctrl.mem_w));

endmodule

//--- logic/reg_file.sv
// 32 x 32-bit integer register file, two async reads and one clocked write
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    output logic [31:0] rs1_data,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // x0 hardwired to zero on the read side
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != 5'd0)
        begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- logic/execute_stage.sv
// execute stage, alu, branch decision and target, registers the writeback bundle
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  ctrl_pkg::dec_ex_t dec_ex,
    output ctrl_pkg::ex_wb_t  ex_wb,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc
);

    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        cond;
    logic        take;

    // second operand, register or immediate
    assign op_b = dec_ex.ctrl.alu_src_imm ? dec_ex.imm : dec_ex.rs2_val;

    always_comb
    begin
        case (dec_ex.alu_op)
            ctrl_pkg::alu_sub: alu_res = dec_ex.rs1_val - op_b;
            ctrl_pkg::alu_and: alu_res = dec_ex.rs1_val & op_b;
            ctrl_pkg::alu_or:  alu_res = dec_ex.rs1_val | op_b;
            ctrl_pkg::alu_slt: alu_res = {31'd0, $signed(dec_ex.rs1_val) < $signed(op_b)};
            default:           alu_res = dec_ex.rs1_val + op_b;
        endcase
    end

    // branch test on the alu result, sub for eq/ne, slt for lt/ge
    always_comb
    begin
        case (dec_ex.funct3)
            rv_isa_pkg::f3_beq: cond = (alu_res == '0);
            rv_isa_pkg::f3_bne: cond = (alu_res != '0);
            rv_isa_pkg::f3_blt: cond = alu_res[0];
            rv_isa_pkg::f3_bge: cond = !alu_res[0];
            default:            cond = 1'b0;
        endcase
    end

    assign take = dec_ex.valid &&
                  ((dec_ex.ctrl.branch && cond) || dec_ex.ctrl.pc_sel == ctrl_pkg::pc_jal);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_wb          <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end
        else
        begin
            ex_wb.valid      <= dec_ex.valid;
            ex_wb.ctrl       <= dec_ex.ctrl;
            ex_wb.alu_res    <= alu_res;
            ex_wb.store_data <= dec_ex.rs2_val;
            ex_wb.link       <= dec_ex.pc + 32'd4;
            ex_wb.rd         <= dec_ex.rd;
            redirect_valid   <= take;
            // same adder target for branches and jal
            redirect_pc      <= dec_ex.pc + dec_ex.imm;
        end
    end

    // redirect only ever comes from a live branch or jal
    a_redirect_class: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> ex_wb.valid &&
                           (ex_wb.ctrl.branch || ex_wb.ctrl.pc_sel == ctrl_pkg::pc_jal));

endmodule

//--- logic/writeback_stage.sv
// writeback stage, data memory access, result select and register write port
`timescale 1ns/1ns

module writeback_stage #(
    parameter int mem_words = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ctrl_pkg::ex_wb_t ex_wb,
    output logic             rf_we,
    output logic [4:0]       rf_waddr,
    output logic [31:0]      rf_wdata,
    output logic             wb_valid,
    output logic [4:0]       wb_rd,
    output logic [31:0]      wb_data,
    output logic             illegal
);

    localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [31:0]   dmem [mem_words];
    logic [aw-1:0] word_idx;
    logic [31:0]   mem_rdata;
    logic [31:0]   result;

    // byte address to word index, wraps at mem_words
    assign word_idx  = aw'((ex_wb.alu_res >> 2) % mem_words);
    // load reads straight through, sees a store from the previous cycle
    assign mem_rdata = dmem[word_idx];

    always_comb
    begin
        case (ex_wb.ctrl.result_sel)
            ctrl_pkg::res_mem:  result = mem_rdata;
            ctrl_pkg::res_link: result = ex_wb.link;
            default:            result = ex_wb.alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < mem_words; i++)
                dmem[i] <= '0;
        end
        else if (ex_wb.valid && ex_wb.ctrl.mem_w)
        begin
            dmem[word_idx] <= ex_wb.store_data;
        end
    end

    assign rf_we    = ex_wb.valid && ex_wb.ctrl.reg_w;
    assign rf_waddr = ex_wb.rd;
    assign rf_wdata = result;

    // x0 writes are dropped, so not reported either
    assign wb_valid = rf_we && (ex_wb.rd != 5'd0);
    assign wb_rd    = ex_wb.rd;
    assign wb_data  = result;
    assign illegal  = ex_wb.valid && ex_wb.ctrl.illegal;

endmodule

//--- logic/rv_exec_top.sv
// top of the three stage rv32i execute pipeline, fed by an external instruction source
`timescale 1ns/1ns

module rv_exec_top #(
    parameter int mem_words = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  rv_isa_pkg::instr_u instr,
    input  logic [31:0]        pc,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    output logic               wb_valid,
    output logic [4:0]         wb_rd,
    output logic [31:0]        wb_data,
    output logic               illegal
);

    logic [4:0]        rs1_addr;
    logic [4:0]        rs2_addr;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic              rf_we;
    logic [4:0]        rf_waddr;
    logic [31:0]       rf_wdata;
    ctrl_pkg::dec_ex_t dec_ex;
    ctrl_pkg::ex_wb_t  ex_wb;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .dec_ex      (dec_ex)
    );

    // written back from the last stage
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .rs2_addr (rs2_addr),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec_ex         (dec_ex),
        .ex_wb          (ex_wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    writeback_stage #(
        .mem_words (mem_words)
    ) u_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_wb    (ex_wb),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .illegal  (illegal)
    );

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock and reset source, 20 ns clock with reset held for the first 16 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release just after the 16th edge, ahead of the first stimulus
    initial
    begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- tb/rv_exec_tb.sv
// testbench for the rv32i execute pipeline that applies an instruction table and checks each result
`timescale 1ns/1ns

module rv_exec_tb;

    // one slot of stimulus plus what must come out two edges later
    typedef struct {
        string       name;
        logic [31:0] word;
        logic [31:0] pc;
        logic        valid;
        logic        exp_wb;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        exp_redir;
        logic [31:0] exp_target;
        logic        exp_illegal;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    rv_isa_pkg::instr_u instr;
    logic [31:0]        pc;
    logic               redirect_valid;
    logic [31:0]        redirect_pc;
    logic               wb_valid;
    logic [4:0]         wb_rd;
    logic [31:0]        wb_data;
    logic               illegal;

    row_t   rows[$];
    bit     table_ready;
    integer seed;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_exec_top #(
        .mem_words (64)
    ) rv_exec_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .illegal        (illegal)
    );

    // encoders with field order straight from the isa formats
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::op_store};
    endfunction

    // byte offset with bit 0 dropped by the format
    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
    endfunction

    // pc of the next row at one word per slot
    function automatic logic [31:0] cur_pc();
        return 32'h100 + 32'(rows.size()) * 32'd4;
    endfunction

    task automatic push_instr(string name, logic [31:0] word, logic exp_wb, logic [4:0] rd,
                              logic [31:0] data, logic exp_redir, logic [31:0] offset,
                              logic exp_illegal);
        row_t r;
        r.name        = name;
        r.word        = word;
        r.pc          = cur_pc();
        r.valid       = 1'b1;
        r.exp_wb      = exp_wb;
        r.exp_rd      = rd;
        r.exp_data    = data;
        r.exp_redir   = exp_redir;
        r.exp_target  = r.pc + offset;
        r.exp_illegal = exp_illegal;
        rows.push_back(r);
    endtask

    // idle slot with an all-zero word that would be illegal if valid
    task automatic push_bubble();
        push_instr("bubble", 32'h0, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, 1'b0);
        rows[rows.size() - 1].valid = 1'b0;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] neg10;
        rnd   = $random(seed);
        imm_a = rnd[11:0];
        rnd   = $random(seed);
        imm_b = rnd[11:0];
        // addi sign-extends its 12-bit immediate
        va    = {{20{imm_a[11]}}, imm_a};
        vb    = {{20{imm_b[11]}}, imm_b};
        neg10 = vb | 32'hffff_ff00;
        push_instr("addi_x1", enc_i(imm_a, 0, 3'b000, 1, 7'h13), 1, 1, va, 0, 0, 0);
        push_instr("addi_x2", enc_i(imm_b, 0, 3'b000, 2, 7'h13), 1, 2, vb, 0, 0, 0);
        push_instr("addi_x3", enc_i(12'd12, 0, 3'b000, 3, 7'h13), 1, 3, 32'd12, 0, 0, 0);
        push_bubble();
        push_instr("add", enc_r(7'd0, 2, 1, 3'b000, 4), 1, 4, va + vb, 0, 0, 0);
        push_instr("sub", enc_r(7'h20, 2, 1, 3'b000, 5), 1, 5, va - vb, 0, 0, 0);
        push_instr("and", enc_r(7'd0, 2, 1, 3'b111, 6), 1, 6, va & vb, 0, 0, 0);
        push_instr("or", enc_r(7'd0, 2, 1, 3'b110, 7), 1, 7, va | vb, 0, 0, 0);
        push_instr("slt", enc_r(7'd0, 2, 1, 3'b010, 8), 1, 8,
                   {31'd0, $signed(va) < $signed(vb)}, 0, 0, 0);
        // rd of x0 is dropped and not reported
        push_instr("addi_x0", enc_i(12'd5, 1, 3'b000, 0, 7'h13), 0, 0, 0, 0, 0, 0);
        push_instr("andi", enc_i(12'h0f0, 1, 3'b111, 9, 7'h13), 1, 9, va & 32'h0f0, 0, 0, 0);
        push_instr("ori", enc_i(12'hf00, 2, 3'b110, 10, 7'h13), 1, 10, neg10, 0, 0, 0);
        push_instr("slti", enc_i(12'd13, 3, 3'b010, 11, 7'h13), 1, 11, 32'd1, 0, 0, 0);
        // store then load of byte address 20
        push_instr("sw", enc_s(12'd8, 1, 3), 0, 0, 0, 0, 0, 0);
        push_instr("lw", enc_i(12'd8, 3, 3'b010, 12, 7'h03), 1, 12, va, 0, 0, 0);
        push_bubble();
        push_bubble();
        push_instr("add_after_lw", enc_r(7'd0, 3, 12, 3'b000, 13), 1, 13, va + 32'd12, 0, 0, 0);
        push_instr("beq_taken", enc_b(13'd16, 1, 1, 3'b000), 0, 0, 0, 1, 32'd16, 0);
        push_instr("beq_not_taken", enc_b(13'd16, 11, 3, 3'b000), 0, 0, 0, 0, 0, 0);
        push_instr("bne_not_taken", enc_b(13'd16, 1, 1, 3'b001), 0, 0, 0, 0, 0, 0);
        push_instr("blt_taken", enc_b(-13'sd8, 3, 10, 3'b100), 0, 0, 0, 1, -32'sd8, 0);
        push_instr("blt_not_taken", enc_b(13'd8, 10, 3, 3'b100), 0, 0, 0, 0, 0, 0);
        push_instr("bge_not_taken", enc_b(13'd24, 3, 10, 3'b101), 0, 0, 0, 0, 0, 0);
        push_instr("bge_taken", enc_b(13'd32, 10, 3, 3'b101), 0, 0, 0, 1, 32'd32, 0);
        push_instr("bne_rand", enc_b(13'd12, 3, 1, 3'b001), 0, 0, 0, va != 32'd12, 32'd12, 0);
        push_instr("jal_link", enc_j(21'd64, 14), 1, 14, cur_pc() + 32'd4, 1, 32'd64, 0);
        // csrrw x17, mstatus, x1
        push_instr("csrrw_illegal", {12'h300, 5'd1, 3'b001, 5'd17, 7'h73}, 0, 0, 0, 0, 0, 1);
        push_instr("zero_word_illegal", 32'h0, 0, 0, 0, 0, 0, 1);
        // imm bit 10 sits where funct7 bit 5 of an r-type would be
        push_instr("addi_after_illegal", enc_i(12'h407, 0, 3'b000, 15, 7'h13), 1, 15, 32'h407,
                   0, 0, 0);
        push_bubble();
        push_bubble();
        push_instr("add_x15", enc_r(7'd0, 1, 15, 3'b000, 16), 1, 16, va + 32'h407, 0, 0, 0);
        // x17 untouched by the csr attempt
        push_instr("add_x17", enc_r(7'd0, 3, 17, 3'b000, 18), 1, 18, 32'd12, 0, 0, 0);
        push_instr("jal_x0", enc_j(-21'sd4, 0), 0, 0, 0, 1, -32'sd4, 0);
    endtask

    task automatic fail_stop(string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(string name, string field, logic [31:0] exp,
                                   logic [31:0] act);
        fail_stop($sformatf("MISMATCH %s %s expected %h actual %h", name, field, exp, act));
    endtask

    task automatic check_idle();
        assert (wb_valid === 1'b0 && redirect_valid === 1'b0 && illegal === 1'b0)
            else fail_stop("an output strobe was active while reset was asserted");
    endtask

    // rd, data and target only matter when their strobe is expected
    task automatic check_row(row_t r);
        assert (wb_valid === r.exp_wb)
            else report_mismatch(r.name, "wb_valid", 32'(r.exp_wb), 32'(wb_valid));
        if (r.exp_wb)
        begin
            assert (wb_rd === r.exp_rd)
                else report_mismatch(r.name, "wb_rd", 32'(r.exp_rd), 32'(wb_rd));
            assert (wb_data === r.exp_data)
                else report_mismatch(r.name, "wb_data", r.exp_data, wb_data);
        end
        assert (redirect_valid === r.exp_redir)
            else report_mismatch(r.name, "redirect_valid", 32'(r.exp_redir),
                                 32'(redirect_valid));
        if (r.exp_redir)
        begin
            assert (redirect_pc === r.exp_target)
                else report_mismatch(r.name, "redirect_pc", r.exp_target, redirect_pc);
        end
        assert (illegal === r.exp_illegal)
            else report_mismatch(r.name, "illegal", 32'(r.exp_illegal), 32'(illegal));
    endtask

    initial
    begin
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        seed        = 49;
        build_table();
        table_ready = 1'b1;
        while (rst_n !== 1'b1)
        begin
            @(posedge clk);
            #2;
            check_idle();
        end
        // row i goes in now and its results show two edges later
        for (int i = 0; i < rows.size() + 2; i++)
        begin
            if (i >= 2)
                check_row(rows[i - 2]);
            if (i < rows.size())
            begin
                instr_valid = rows[i].valid;
                instr       = rows[i].word;
                pc          = rows[i].pc;
            end
            else
            begin
                instr_valid = 1'b0;
                instr       = '0;
                pc          = '0;
            end
            @(posedge clk);
            #2;
        end
        $display("All checks passed");
        $finish;
    end

    // watchdog over the table length plus margin for reset and drain
    initial
    begin
        wait (table_ready);
        repeat (rows.size() + 40) @(posedge clk);
        fail_stop("watchdog expired before the instruction table finished");
    end

endmodule

//--- all.f
common/rv_isa_pkg.sv
common/ctrl_pkg.sv
decode/main_deco.sv
decode/alu_deco.sv
decode/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv_exec_top.sv
tb/tb_clock_gen.sv
tb/rv_exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the rv_exec pipeline testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module rv_exec_tb -Mdir obj_dir \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vrv_exec_tb > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "All checks passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
